/* Bender.yml */
package:
  name: cpl_merge

sources:
  - cplm_pkg.sv
  - tag_meta_table.sv
  - req_len_recorder.sv
  - cpl_piece_aligner.sv
  - cpl_beat_merger.sv
  - cpl_merge.sv
  - target: test
    files:
      - cpl_merge_tb_clk.sv
      - cpl_merge_tb.sv

/* cpl_beat_merger.sv */
`timescale 1ns/1ps
`default_nettype none

// Second merge stage
// Joins rotated beats with the leftover lanes of the previous beat
// and puts the original length and metadata back into the header
module cpl_beat_merger
    import cplm_pkg::*;
#(
    parameter int BUS_BYTES = cplm_pkg::BUS_BYTES
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  cpl_beat_t            i_beat,
    input  logic                 i_beat_valid,
    output logic                 o_beat_ready,
    input  logic [BUS_BYTES-1:0] i_rot_mask,
    input  logic [LEN_W-1:0]     i_tbl_meta,

    output cpl_beat_t            o_cpl,
    output logic                 o_cpl_valid,
    input  logic                 i_cpl_ready
);

    localparam int DW = BUS_BYTES * 8;

    logic                 adv;
    logic                 accept;
    logic                 emit;
    logic                 must_drain;
    logic                 drain_next;
    logic                 in_sop;
    logic                 out_sop;
    logic [DW-1:0]        prev_data;
    logic [BUS_BYTES-1:0] prev_keep;
    logic [DW-1:0]        mrg_data;
    logic [BUS_BYTES-1:0] mrg_keep;
    logic [DW-1:0]        drn_data;
    cpl_hdr_t             hdr_q;
    cpl_hdr_t             hdr_src;
    cpl_hdr_t             hdr_rst;

    assign adv          = !o_cpl_valid || i_cpl_ready;
    assign o_beat_ready = adv && !must_drain;
    assign accept       = i_beat_valid && o_beat_ready;

    // A beat is complete once its top lane is filled or the packet ends
    assign emit = i_beat.keep[BUS_BYTES-1] || i_beat.last;

    // Wrapped bytes of the final beat need one more output beat
    assign drain_next = !i_rot_mask[0] && i_beat.keep[0];

    // ============================================================
    // Lane select and header restore
    // ============================================================

    always_comb begin
        mrg_keep = (~i_rot_mask & prev_keep) | (i_rot_mask & i_beat.keep);
        for (int i = 0; i < BUS_BYTES; i++) begin
            mrg_data[i*8 +: 8] = i_rot_mask[i] ? i_beat.data[i*8 +: 8] : prev_data[i*8 +: 8];
            if (!mrg_keep[i]) begin
                mrg_data[i*8 +: 8] = '0;
            end
            drn_data[i*8 +: 8] = prev_keep[i] ? prev_data[i*8 +: 8] : 8'h00;
        end
    end

    // The packet header may have arrived on an earlier beat
    assign hdr_src = in_sop ? i_beat.hdr : hdr_q;

    // The length rode in the metadata field on the way out
    always_comb begin
        hdr_rst      = hdr_src;
        hdr_rst.len  = hdr_src.meta;
        hdr_rst.meta = i_tbl_meta;
        hdr_rst.fc   = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_cpl_valid <= 1'b0;
            must_drain  <= 1'b0;
            prev_keep   <= '1;
            in_sop      <= 1'b1;
            out_sop     <= 1'b1;
        end else begin
            if (adv) begin
                o_cpl_valid <= 1'b0;
            end
            if (adv && must_drain) begin
                o_cpl_valid <= 1'b1;
                must_drain  <= 1'b0;
                prev_keep   <= '1;
                out_sop     <= 1'b1;
            end else if (accept) begin
                o_cpl_valid <= emit;
                must_drain  <= i_beat.last && drain_next;
                in_sop      <= i_beat.last;
                if (i_beat.last && !drain_next) begin
                    prev_keep <= '1;
                end else begin
                    prev_keep <= i_beat.keep & ~i_rot_mask;
                end
                if (emit) begin
                    out_sop <= i_beat.last && !drain_next;
                end
            end
        end
    end

    // Output payload, the table value is sampled with the first beat
    always_ff @(posedge clk) begin
        if (adv && must_drain) begin
            o_cpl.hdr  <= '0;
            o_cpl.data <= drn_data;
            o_cpl.keep <= prev_keep;
            o_cpl.last <= 1'b1;
        end else if (accept) begin
            o_cpl.hdr  <= out_sop ? hdr_rst : '0;
            o_cpl.data <= mrg_data;
            o_cpl.keep <= mrg_keep;
            o_cpl.last <= i_beat.last && !drain_next;
            prev_data  <= i_beat.data;
            if (in_sop) begin
                hdr_q <= i_beat.hdr;
            end
        end
    end

endmodule

`default_nettype wire

/* cpl_merge.f */
cplm_pkg.sv
tag_meta_table.sv
req_len_recorder.sv
cpl_piece_aligner.sv
cpl_beat_merger.sv
cpl_merge.sv
cpl_merge_tb_clk.sv
cpl_merge_tb.sv

/* cpl_merge.sv */
`timescale 1ns/1ps
`default_nettype none

// Merges split read completions back into one completion per read
module cpl_merge
    import cplm_pkg::*;
#(
    parameter int BUS_BYTES = cplm_pkg::BUS_BYTES
) (
    input  logic      clk,
    input  logic      rst_n,

    // Read requests on their way to the splitter
    input  req_beat_t i_req,
    input  logic      i_req_valid,
    output logic      o_req_ready,
    output req_beat_t o_req,
    output logic      o_req_valid,
    input  logic      i_req_ready,

    // Split completions in, merged completions out
    input  cpl_beat_t i_cpl,
    input  logic      i_cpl_valid,
    output logic      o_cpl_ready,
    output cpl_beat_t o_cpl,
    output logic      o_cpl_valid,
    input  logic      i_cpl_ready,

    // Sticky, stays high until reset
    output logic      o_error
);

    logic                 tbl_wr_en;
    logic [TAG_W-1:0]     tbl_wr_tag;
    logic [LEN_W-1:0]     tbl_wr_meta;
    logic                 tbl_rd_en;
    logic [TAG_W-1:0]     tbl_rd_tag;
    logic [LEN_W-1:0]     tbl_rd_meta;
    cpl_beat_t            algn_beat;
    logic                 algn_valid;
    logic                 algn_ready;
    logic [BUS_BYTES-1:0] rot_mask;

    // ============================================================
    // Request side
    // ============================================================

    req_len_recorder u_recorder (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_req         (i_req),
        .i_req_valid   (i_req_valid),
        .o_req_ready   (o_req_ready),
        .o_req         (o_req),
        .o_req_valid   (o_req_valid),
        .i_req_ready   (i_req_ready),
        .o_tbl_wr_en   (tbl_wr_en),
        .o_tbl_wr_tag  (tbl_wr_tag),
        .o_tbl_wr_meta (tbl_wr_meta)
    );

    tag_meta_table u_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_wr_en   (tbl_wr_en),
        .i_wr_tag  (tbl_wr_tag),
        .i_wr_meta (tbl_wr_meta),
        .i_rd_en   (tbl_rd_en),
        .i_rd_tag  (tbl_rd_tag),
        .o_rd_meta (tbl_rd_meta)
    );

    // ============================================================
    // Completion side
    // ============================================================

    cpl_piece_aligner #(
        .BUS_BYTES (BUS_BYTES)
    ) u_aligner (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_cpl        (i_cpl),
        .i_cpl_valid  (i_cpl_valid),
        .o_cpl_ready  (o_cpl_ready),
        .o_beat       (algn_beat),
        .o_beat_valid (algn_valid),
        .i_beat_ready (algn_ready),
        .o_rot_mask   (rot_mask),
        .o_tbl_rd_en  (tbl_rd_en),
        .o_tbl_rd_tag (tbl_rd_tag),
        .o_error      (o_error)
    );

    cpl_beat_merger #(
        .BUS_BYTES (BUS_BYTES)
    ) u_merger (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_beat       (algn_beat),
        .i_beat_valid (algn_valid),
        .o_beat_ready (algn_ready),
        .i_rot_mask   (rot_mask),
        .i_tbl_meta   (tbl_rd_meta),
        .o_cpl        (o_cpl),
        .o_cpl_valid  (o_cpl_valid),
        .i_cpl_ready  (i_cpl_ready)
    );

endmodule

`default_nettype wire

/* cpl_merge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// Testbench for the completion merge path
module cpl_merge_tb
    import cplm_pkg::*;
();

    localparam int BB         = BUS_BYTES;
    localparam int N_UNSPLIT  = 10;
    localparam int N_SPLIT    = 40;
    // Non-read request, unsplit reads, split reads and the error case
    localparam int N_TXN      = 1 + N_UNSPLIT + N_SPLIT + 1;
    localparam int TIMEOUT_NS = (N_TXN * 40 + 100) * 4;

    logic      clk;
    logic      rst_n;
    req_beat_t i_req;
    logic      i_req_valid;
    logic      o_req_ready;
    req_beat_t o_req;
    logic      o_req_valid;
    logic      i_req_ready;
    cpl_beat_t i_cpl;
    logic      i_cpl_valid;
    logic      o_cpl_ready;
    cpl_beat_t o_cpl;
    logic      o_cpl_valid;
    logic      i_cpl_ready;
    logic      o_error;

    // State of the random generator
    logic [31:0] rng_state = 32'h5a8f_684e;

    // Reference model of the current read
    logic [7:0]       exp_bytes[$];
    int               piece_lens[$];
    int               exp_len;
    logic [TAG_W-1:0] exp_tag;
    logic [LEN_W-1:0] exp_meta;
    logic             stall_en;

    cpl_merge_tb_clk u_clk (
        .o_clk (clk)
    );

    cpl_merge #(
        .BUS_BYTES (BB)
    ) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_req       (i_req),
        .i_req_valid (i_req_valid),
        .o_req_ready (o_req_ready),
        .o_req       (o_req),
        .o_req_valid (o_req_valid),
        .i_req_ready (i_req_ready),
        .i_cpl       (i_cpl),
        .i_cpl_valid (i_cpl_valid),
        .o_cpl_ready (o_cpl_ready),
        .o_cpl       (o_cpl),
        .o_cpl_valid (o_cpl_valid),
        .i_cpl_ready (i_cpl_ready),
        .o_error     (o_error)
    );

    // ============================================================
    // Helpers
    // ============================================================

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic report_fail();
        $display("FAIL: see errors above");
        $fatal(1, "stopping at the first error");
    endtask

    // Offers one completion beat and returns on the edge that takes it
    task automatic send_beat(input cpl_beat_t b);
        logic took;
        @(negedge clk);
        i_cpl       = b;
        i_cpl_valid = 1'b1;
        #1;
        took = o_cpl_ready;
        while (!took) begin
            @(negedge clk);
            #1;
            took = o_cpl_ready;
        end
        @(posedge clk);
    endtask

    // Each piece starts at lane 0 and carries its header on the first beat
    task automatic send_piece(input int off, input int plen, input logic fc);
        cpl_beat_t beat;
        int        nb;
        int        idx;
        nb = (plen + BB - 1) / BB;
        for (int b = 0; b < nb; b++) begin
            beat = '0;
            if (b == 0) begin
                beat.hdr.is_cpl = 1'b1;
                beat.hdr.tag    = exp_tag;
                beat.hdr.len    = LEN_W'(plen);
                beat.hdr.fc     = fc;
                // The splitter copies the recorded length into every piece
                beat.hdr.meta   = LEN_W'(exp_len);
            end
            for (int lane = 0; lane < BB; lane++) begin
                idx = b * BB + lane;
                if (idx < plen) begin
                    beat.data[lane*8 +: 8] = exp_bytes[off + idx];
                    beat.keep[lane]        = 1'b1;
                end
            end
            beat.last = (b == nb - 1);
            send_beat(beat);
        end
    endtask

    task automatic drive_pieces();
        int off;
        off = 0;
        for (int p = 0; p < piece_lens.size(); p++) begin
            send_piece(off, piece_lens[p], p == piece_lens.size() - 1);
            off = off + piece_lens[p];
        end
        @(negedge clk);
        i_cpl_valid = 1'b0;
    endtask

    // Drives one request and checks the pass-through copy
    task automatic send_request(input req_hdr_t h);
        req_beat_t exp;
        @(negedge clk);
        i_req.hdr   = h;
        i_req.last  = 1'b1;
        i_req_valid = 1'b1;
        i_req_ready = 1'b1;
        #1;
        exp.hdr  = h;
        exp.last = 1'b1;
        // Reads carry their length in the metadata field downstream
        if (h.is_read) begin
            exp.hdr.meta = h.len;
        end
        assert (o_req_valid && o_req_ready && o_req == exp) else begin
            $display("error at %0t: request %h came out as %h", $time, exp, o_req);
            report_fail();
        end
        @(posedge clk);
        @(negedge clk);
        i_req_valid = 1'b0;
    endtask

    // Takes the merged packet and compares it with the reference bytes
    task automatic collect_packet();
        cpl_beat_t    ob;
        logic         took;
        logic         done;
        int           nbeats;
        int           pos;
        int           exp_beats;
        int           cnt;
        logic [BB-1:0] exp_keep;
        nbeats    = 0;
        pos       = 0;
        done      = 1'b0;
        exp_beats = (exp_len + BB - 1) / BB;
        while (!done) begin
            @(negedge clk);
            // Roughly one cycle in four is stalled in back-pressure runs
            i_cpl_ready = !(stall_en && xorshift() % 4 == 0);
            #1;
            took = o_cpl_valid && i_cpl_ready;
            ob   = o_cpl;
            if (took) begin
                if (nbeats == 0) begin
                    assert (ob.hdr.is_cpl && ob.hdr.fc && ob.hdr.tag == exp_tag
                            && ob.hdr.len == LEN_W'(exp_len) && ob.hdr.meta == exp_meta)
                    else begin
                        $display("error at %0t: merged header %h, want tag %h len %0d meta %h",
                                 $time, ob.hdr, exp_tag, exp_len, exp_meta);
                        report_fail();
                    end
                end
                // The last flag on the expected beat also fixes the beat count
                cnt = (nbeats == exp_beats - 1) ? exp_len - nbeats * BB : BB;
                for (int lane = 0; lane < BB; lane++) begin
                    exp_keep[lane] = (lane < cnt);
                end
                assert (ob.keep == exp_keep && ob.last == (nbeats == exp_beats - 1)) else begin
                    $display("error at %0t: beat %0d keep %b last %b, want keep %b",
                             $time, nbeats, ob.keep, ob.last, exp_keep);
                    report_fail();
                end
                for (int lane = 0; lane < cnt; lane++) begin
                    assert (ob.data[lane*8 +: 8] == exp_bytes[pos + lane]) else begin
                        $display("error at %0t: byte %0d is %h, want %h", $time, pos + lane,
                                 ob.data[lane*8 +: 8], exp_bytes[pos + lane]);
                        report_fail();
                    end
                end
                pos    = pos + cnt;
                nbeats = nbeats + 1;
                done   = ob.last;
            end
        end
    endtask

    // Builds a random read, its pieces, and runs it through the DUT
    task automatic run_read(input logic split, input logic stall);
        req_hdr_t h;
        int       rem;
        int       m;
        exp_tag  = TAG_W'(xorshift());
        exp_len  = 1 + xorshift() % 64;
        exp_meta = LEN_W'(xorshift());
        stall_en = stall;
        exp_bytes.delete();
        piece_lens.delete();
        for (int i = 0; i < exp_len; i++) begin
            exp_bytes.push_back(8'(xorshift()));
        end
        if (!split || exp_len < 2) begin
            piece_lens.push_back(exp_len);
        end else begin
            // The first piece may have any size and middle pieces are whole bus widths
            piece_lens.push_back(1 + xorshift() % (exp_len - 1));
            rem = exp_len - piece_lens[0];
            while (rem > BB && xorshift() % 2 == 1) begin
                m = BB * (1 + xorshift() % ((rem - 1) / BB));
                piece_lens.push_back(m);
                rem = rem - m;
            end
            piece_lens.push_back(rem);
        end
        h.is_read = 1'b1;
        h.tag     = exp_tag;
        h.len     = LEN_W'(exp_len);
        h.meta    = exp_meta;
        send_request(h);
        // Completions trail their request by at least two cycles
        repeat (2) @(negedge clk);
        fork
            drive_pieces();
            collect_packet();
        join
    endtask

    // A middle piece with a foreign tag must lock the input
    task automatic run_error();
        req_hdr_t  h;
        cpl_beat_t beat;
        exp_tag  = TAG_W'(xorshift());
        exp_len  = 24;
        exp_meta = LEN_W'(xorshift());
        exp_bytes.delete();
        for (int i = 0; i < exp_len; i++) begin
            exp_bytes.push_back(8'(xorshift()));
        end
        h.is_read = 1'b1;
        h.tag     = exp_tag;
        h.len     = LEN_W'(exp_len);
        h.meta    = exp_meta;
        send_request(h);
        repeat (2) @(negedge clk);
        i_cpl_ready = 1'b1;
        send_piece(0, BB, 1'b0);
        exp_tag = exp_tag ^ 8'h5a;
        send_piece(BB, BB, 1'b0);
        // Keep offering beats and make sure none of them is taken
        beat      = '0;
        beat.keep = '1;
        beat.last = 1'b1;
        @(negedge clk);
        i_cpl       = beat;
        i_cpl_valid = 1'b1;
        repeat (10) begin
            #1;
            assert (o_error === 1'b1 && o_cpl_ready === 1'b0) else begin
                $display("error at %0t: o_error %b o_cpl_ready %b after a tag mismatch",
                         $time, o_error, o_cpl_ready);
                report_fail();
            end
            @(negedge clk);
        end
        i_cpl_valid = 1'b0;
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        req_hdr_t h;
        rst_n       = 1'b0;
        i_req       = '0;
        i_req_valid = 1'b0;
        i_req_ready = 1'b0;
        i_cpl       = '0;
        i_cpl_valid = 1'b0;
        i_cpl_ready = 1'b1;
        stall_en    = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        assert (!o_cpl_valid && !o_error && o_cpl_ready) else begin
            $display("error at %0t: bad state after reset", $time);
            report_fail();
        end

        // A write request passes with its metadata untouched
        h.is_read = 1'b0;
        h.tag     = TAG_W'(xorshift());
        h.len     = LEN_W'(xorshift());
        h.meta    = LEN_W'(xorshift());
        send_request(h);

        for (int i = 0; i < N_UNSPLIT; i++) begin
            run_read(1'b0, i % 2 == 1);
        end
        for (int i = 0; i < N_SPLIT; i++) begin
            run_read(1'b1, i >= N_SPLIT / 2);
        end
        run_error();

        $display("PASS: all tests");
        $finish;
    end

    // Watchdog sized from the number of transactions
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: the run did not finish within %0d ns", TIMEOUT_NS);
        report_fail();
    end

endmodule

`default_nettype wire

/* cpl_merge_tb_clk.sv */
`timescale 1ns/1ps
`default_nettype none

// Free-running testbench clock, 4 ns period
module cpl_merge_tb_clk #(
    parameter real HALF_NS = 2.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    // Toggle every half period
    always #(HALF_NS) o_clk = ~o_clk;

endmodule

`default_nettype wire

/* cpl_piece_aligner.sv */
`timescale 1ns/1ps
`default_nettype none

// First merge stage
// Follows piece boundaries, rotates data of later pieces into place
// and builds the lane mask used by the merger
module cpl_piece_aligner
    import cplm_pkg::*;
#(
    parameter int BUS_BYTES = cplm_pkg::BUS_BYTES
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  cpl_beat_t            i_cpl,
    input  logic                 i_cpl_valid,
    output logic                 o_cpl_ready,

    output cpl_beat_t            o_beat,
    output logic                 o_beat_valid,
    input  logic                 i_beat_ready,
    output logic [BUS_BYTES-1:0] o_rot_mask,

    output logic                 o_tbl_rd_en,
    output logic [TAG_W-1:0]     o_tbl_rd_tag,
    output logic                 o_error
);

    localparam int ROT_W = $clog2(BUS_BYTES);
    localparam int DW    = BUS_BYTES * 8;

    logic                 accept;
    logic                 piece_sop;
    logic                 orig_sop;
    logic                 first_q;
    logic                 fc_q;
    logic                 final_q;
    logic                 hdr_fc;
    logic                 cur_first;
    logic                 cur_fc;
    logic                 final_last;
    logic [ROT_W-1:0]     rot_next;
    logic [ROT_W-1:0]     rot_cur;
    logic [TAG_W-1:0]     tag_q;
    logic [2*DW-1:0]      data_dbl;
    logic [2*BUS_BYTES-1:0] keep_dbl;

    // ============================================================
    // Piece tracking
    // ============================================================

    // The output register takes a beat when it is empty or emptying
    assign o_cpl_ready = (!o_beat_valid || i_beat_ready) && !o_error;
    assign accept      = i_cpl_valid && o_cpl_ready;

    // A non-completion can never be split, so it is its own final piece
    assign hdr_fc = !i_cpl.hdr.is_cpl || i_cpl.hdr.fc;

    // Header flags are only present on the first beat of a piece
    assign cur_first  = piece_sop ? orig_sop : first_q;
    assign cur_fc     = piece_sop ? hdr_fc : fc_q;
    assign final_last = i_cpl.last && cur_fc;

    // Later pieces all start bus aligned, so one rotation serves them all
    assign rot_cur = cur_first ? '0 : rot_next;

    // Metadata is looked up once per original read
    assign o_tbl_rd_en  = accept && piece_sop && orig_sop;
    assign o_tbl_rd_tag = i_cpl.hdr.tag;

    // ============================================================
    // Byte rotation upward by rot_cur lanes
    // ============================================================

    assign data_dbl = {i_cpl.data, i_cpl.data} << {rot_cur, 3'b000};
    assign keep_dbl = {i_cpl.keep, i_cpl.keep} << rot_cur;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_beat_valid <= 1'b0;
            piece_sop    <= 1'b1;
            orig_sop     <= 1'b1;
            first_q      <= 1'b1;
            fc_q         <= 1'b1;
            final_q      <= 1'b0;
            rot_next     <= '0;
            o_rot_mask   <= '1;
            o_error      <= 1'b0;
        end else begin
            if (i_beat_ready) begin
                o_beat_valid <= 1'b0;
            end
            if (accept) begin
                o_beat_valid <= 1'b1;
                piece_sop    <= i_cpl.last;
                final_q      <= final_last;

                if (piece_sop) begin
                    orig_sop <= hdr_fc;
                    first_q  <= orig_sop;
                    fc_q     <= hdr_fc;
                    if (orig_sop) begin
                        // Bytes of the first piece left over above the bus width
                        rot_next <= i_cpl.hdr.len[ROT_W-1:0];
                    end else if (i_cpl.hdr.tag != tag_q || !i_cpl.hdr.is_cpl) begin
                        // Another read or a non-completion broke into the split
                        o_error <= 1'b1;
                    end
                end

                // The previous packet has left the register, drop its mask
                if (final_q) begin
                    o_rot_mask <= '1;
                end

                // Free lanes of the first piece's last beat take the next piece
                if (i_cpl.last && cur_first && !cur_fc) begin
                    o_rot_mask <= i_cpl.keep[BUS_BYTES-1] ? '1 : ~i_cpl.keep;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_beat.hdr  <= cur_first ? i_cpl.hdr : '0;
            o_beat.data <= data_dbl[2*DW-1 -: DW];
            o_beat.keep <= keep_dbl[2*BUS_BYTES-1 -: BUS_BYTES];
            o_beat.last <= final_last;
            if (piece_sop && orig_sop) begin
                tag_q <= i_cpl.hdr.tag;
            end
        end
    end

endmodule

`default_nettype wire

/* cplm_pkg.sv */
`default_nettype none

// ============================================================
// Shared widths and structs for the completion merge path
// ============================================================

package cplm_pkg;

    // Default data bus width in bytes, the top level passes it down
    localparam int BUS_BYTES = 8;

    // Request tag width, the metadata table has 2**TAG_W entries
    localparam int TAG_W = 8;

    // Byte length width, also the width of the saved metadata
    localparam int LEN_W = 24;

    // Request header as seen on the request channel
    typedef struct packed {
        logic             is_read;
        logic [TAG_W-1:0] tag;
        logic [LEN_W-1:0] len;
        logic [LEN_W-1:0] meta;
    } req_hdr_t;

    // Requests are header-only, so one beat carries a whole header
    typedef struct packed {
        req_hdr_t hdr;
        logic     last;
    } req_beat_t;

    // Completion header, fc marks the final piece of a read
    typedef struct packed {
        logic             is_cpl;
        logic [TAG_W-1:0] tag;
        logic [LEN_W-1:0] len;
        logic             fc;
        logic [LEN_W-1:0] meta;
    } cpl_hdr_t;

    // One completion beat
    // The header is only meaningful on the first beat of a piece
    typedef struct packed {
        cpl_hdr_t               hdr;
        logic [BUS_BYTES*8-1:0] data;
        logic [BUS_BYTES-1:0]   keep;
        logic                   last;
    } cpl_beat_t;

endpackage

`default_nettype wire

/* req_len_recorder.sv */
`timescale 1ns/1ps
`default_nettype none

// Request pass-through that records the length of every read
module req_len_recorder
    import cplm_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,

    // Upstream request channel
    input  req_beat_t        i_req,
    input  logic             i_req_valid,
    output logic             o_req_ready,

    // Downstream request channel
    output req_beat_t        o_req,
    output logic             o_req_valid,
    input  logic             i_req_ready,

    // Write port of the metadata table
    output logic             o_tbl_wr_en,
    output logic [TAG_W-1:0] o_tbl_wr_tag,
    output logic [LEN_W-1:0] o_tbl_wr_meta
);

    logic req_sop;
    logic req_accept;
    logic is_read;

    // Zero-latency path, the handshake goes straight through
    assign o_req_valid = i_req_valid;
    assign o_req_ready = i_req_ready;
    assign req_accept  = i_req_valid && i_req_ready;

    // Only a header beat may be taken as a read
    assign is_read = req_sop && i_req.hdr.is_read;

    // The length travels in the metadata field so that the merger
    // knows the full size of the read when pieces come back
    always_comb begin
        o_req = i_req;
        if (is_read) begin
            o_req.hdr.meta = i_req.hdr.len;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_sop     <= 1'b1;
            o_tbl_wr_en <= 1'b0;
        end else begin
            o_tbl_wr_en <= req_accept && is_read;
            if (req_accept) begin
                req_sop <= i_req.last;
            end
        end
    end

    // Original metadata is saved one cycle after the request is taken
    always_ff @(posedge clk) begin
        if (req_accept && is_read) begin
            o_tbl_wr_tag  <= i_req.hdr.tag;
            o_tbl_wr_meta <= i_req.hdr.meta;
        end
    end

endmodule

`default_nettype wire

/* tag_meta_table.sv */
`timescale 1ns/1ps
`default_nettype none

// Tag-indexed store of the original metadata of each outstanding read
module tag_meta_table
    import cplm_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,

    // Write port, driven from the request path
    input  logic             i_wr_en,
    input  logic [TAG_W-1:0] i_wr_tag,
    input  logic [LEN_W-1:0] i_wr_meta,

    // Registered read port, driven from the completion path
    input  logic             i_rd_en,
    input  logic [TAG_W-1:0] i_rd_tag,
    output logic [LEN_W-1:0] o_rd_meta
);

    // One entry per tag
    logic [LEN_W-1:0] mem [0:(1 << TAG_W)-1];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_tag] <= i_wr_meta;
        end
    end

    // The read register only moves on a read, so the value stays put
    // until the merger has restored the header of the current packet
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_rd_meta <= '0;
        end else if (i_rd_en) begin
            o_rd_meta <= mem[i_rd_tag];
        end
    end

endmodule

`default_nettype wire
